//--- sources.f
hw/cgra_init_pkg.sv
hw/cgra_initial_conf_control.sv
hw/pe_init_slot.sv
hw/pe_conf_readout.sv
hw/cgra_init_top.sv
bench/cgra_init_checker.sv
bench/tb_cgra_init_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cgra_init_top \
  -f sources.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
  exit 1
fi
exit 0

//--- bench/tb_cgra_init_top.sv
`timescale 1ns/1ns

module tb_cgra_init_top import cgra_init_pkg::*; ();

  localparam int NUM_PE          = 8;
  localparam int PERIOD          = 40;
  localparam int NUM_LINES       = 5;
  localparam int NUM_READS       = 17;
  localparam int WATCHDOG_CYCLES = 40 * NUM_LINES + 20 * NUM_READS + 200;

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic                  available_read;
  logic [LINE_W-1:0]     rd_data;
  logic                  rd_data_valid;
  logic                  rd_req;
  logic [PE_ID_W-1:0]    rd_sel;
  logic                  req_rd_data;
  logic [31:0]           qtd_conf;
  logic [31:0]           qtd_net_conf;
  logic [1:0]            read_fifo_mask;
  logic [1:0]            write_fifo_mask;
  logic                  done;
  logic                  rd_ack;
  logic [INIT_BUS_W-1:0] rd_rec;
  logic                  rd_loaded;

  logic [LINE_W-1:0]     image [0:3];
  logic [INIT_BUS_W-1:0] exp_rec [0:MAX_PE-1];
  logic                  exp_loaded [0:MAX_PE-1];
  logic [31:0]           hdr_conf;
  logic [31:0]           hdr_net;
  logic [1:0]            hdr_rmask;
  logic [1:0]            hdr_wmask;
  logic [INIT_BUS_W-1:0] got_rec;
  logic                  got_loaded;
  logic [31:0]           rand_state = 32'he10c_b037;
  int                    errors = 0;
  int                    checks = 0;
  int                    req_cnt = 0;

  cgra_init_top #(
    .NUM_PE (NUM_PE)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .available_read  (available_read),
    .rd_data         (rd_data),
    .rd_data_valid   (rd_data_valid),
    .rd_req          (rd_req),
    .rd_sel          (rd_sel),
    .req_rd_data     (req_rd_data),
    .qtd_conf        (qtd_conf),
    .qtd_net_conf    (qtd_net_conf),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (done),
    .rd_ack          (rd_ack),
    .rd_rec          (rd_rec),
    .rd_loaded       (rd_loaded)
  );

  bind cgra_init_top cgra_init_checker u_chk (
    .clk         (clk),
    .rst         (rst),
    .req_rd_data (req_rd_data),
    .done        (done),
    .rd_req      (rd_req),
    .rd_ack      (rd_ack),
    .rd_rec      (rd_rec)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // LCG, upper half only
  function automatic logic [15:0] rand16();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state[31:16];
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    checks++;
    assert (exp === act) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  // Random lines with header and record fields written over them
  task automatic build_image(input int count);
    logic [REC_W-1:0]   slice;
    logic [PE_ID_W-1:0] id;
    logic [PE_ID_W-1:0] repeat_id;
    repeat_id = '0;
    for (int l = 0; l < 4; l++) begin
      for (int w = 0; w < LINE_W / 16; w++) begin
        image[l][w*16 +: 16] = rand16();
      end
    end
    image[0][HDR_COUNT_OFS +: 32] = count;
    hdr_conf  = image[0][HDR_CONF_OFS +: 32];
    hdr_net   = image[0][HDR_NET_OFS +: 32];
    hdr_rmask = image[0][HDR_RMASK_OFS +: 2];
    hdr_wmask = image[0][HDR_WMASK_OFS +: 2];
    for (int i = 0; i < MAX_PE; i++) begin
      exp_rec[i]    = '0;
      exp_loaded[i] = 1'b0;
    end
    for (int r = 0; r < count; r++) begin
      slice = image[1 + r / 4][(r % 4) * REC_W +: REC_W];
      id = PE_ID_W'(rand16() % 16'(NUM_PE));
      if (r == 1) repeat_id = id;
      if (r == 5) id = PE_ID_W'(9);
      if (r == 7) id = repeat_id;
      slice[REC_ID_OFS +: PE_ID_W] = id;
      image[1 + r / 4][(r % 4) * REC_W +: REC_W] = slice;
      if (int'(id) < NUM_PE) begin
        exp_rec[id] = {slice[REC_IGNORE_OFS +: IGNORE_W], slice[REC_LOOP_OFS +: LOOP_W],
                       slice[REC_PC_MAX_OFS +: PC_MAX_W], slice[REC_CONST_OFS +: CONST_W],
                       id};
        exp_loaded[id] = 1'b1;
      end
    end
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
  endtask

  task automatic run_config(input int max_cycles);
    int n;
    start = 1'b1;
    @(posedge clk);
    #2;
    start = 1'b0;
    n = 0;
    while (!done && n < max_cycles) begin
      @(posedge clk);
      #2;
      n++;
    end
    checks++;
    assert (done) else begin
      $display("done did not rise within %0d cycles of start", max_cycles);
      errors++;
    end
  endtask

  // Four-phase readout, the next request may follow at once
  task automatic read_slot(input int sel);
    int n;
    rd_sel = PE_ID_W'(sel);
    rd_req = 1'b1;
    n = 0;
    while (!rd_ack && n < 8) begin
      @(posedge clk);
      #2;
      n++;
    end
    checks++;
    assert (rd_ack) else begin
      $display("readout of slot %0d was never acknowledged", sel);
      errors++;
    end
    got_rec    = rd_rec;
    got_loaded = rd_loaded;
    rd_req = 1'b0;
    n = 0;
    while (rd_ack && n < 8) begin
      @(posedge clk);
      #2;
      n++;
    end
    checks++;
    assert (!rd_ack) else begin
      $display("rd_ack for slot %0d stayed high after rd_req fell", sel);
      errors++;
    end
  endtask

  task automatic check_slots(input string test);
    for (int i = 0; i < NUM_PE; i++) begin
      read_slot(i);
      check_value($sformatf("%s slot %0d record", test, i), 64'(exp_rec[i]), 64'(got_rec));
      check_value($sformatf("%s slot %0d loaded", test, i), 64'(exp_loaded[i]),
                  64'(got_loaded));
    end
  endtask

  // Memory model with random latency and back-pressure
  initial begin
    int   wait_cnt;
    int   stall_cnt;
    int   line_idx;
    logic rst_seen;
    wait_cnt       = 0;
    stall_cnt      = 0;
    line_idx       = 0;
    available_read = 1'b1;
    rd_data_valid  = 1'b0;
    rd_data        = '0;
    forever begin
      @(posedge clk);
      rst_seen = rst;
      #2;
      rd_data_valid = 1'b0;
      rd_data       = '0;
      if (rst_seen) begin
        wait_cnt       = 0;
        stall_cnt      = 0;
        line_idx       = 0;
        req_cnt        = 0;
        available_read = 1'b1;
      end else begin
        if (req_rd_data) begin
          checks++;
          assert (available_read) else begin
            $display("req_rd_data was raised while available_read was low");
            errors++;
          end
          req_cnt++;
          wait_cnt = 1 + int'(rand16() % 16'd4);
        end else if (wait_cnt > 0) begin
          wait_cnt--;
          if (wait_cnt == 0) begin
            rd_data_valid = 1'b1;
            rd_data       = image[line_idx];
            line_idx++;
          end
        end
        if (stall_cnt > 0) begin
          stall_cnt--;
          available_read = (stall_cnt == 0);
        end else if (rand16() % 16'd6 == 16'd0) begin
          available_read = 1'b0;
          stall_cnt      = 1 + int'(rand16() % 16'd5);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    start  = 1'b0;
    rd_req = 1'b0;
    rd_sel = '0;
    apply_reset();

    // Ten records over three record lines, one repeated id, one out of range
    build_image(10);
    run_config(40 * 4);
    check_value("header qtd_conf", 64'(hdr_conf), 64'(qtd_conf));
    check_value("header qtd_net_conf", 64'(hdr_net), 64'(qtd_net_conf));
    check_value("header read_fifo_mask", 64'(hdr_rmask), 64'(read_fifo_mask));
    check_value("header write_fifo_mask", 64'(hdr_wmask), 64'(write_fifo_mask));
    check_value("line fetch count", 64'(1 + (10 + 3) / 4), 64'(req_cnt));
    check_slots("delivery");
    read_slot(9);
    check_value("slot 9 record", 64'(0), 64'(got_rec));
    check_value("slot 9 loaded", 64'(0), 64'(got_loaded));

    // Header only
    apply_reset();
    build_image(0);
    run_config(40);
    check_value("zero count fetch count", 64'(1), 64'(req_cnt));
    check_slots("zero count");

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, u_dut.u_chk.fail_cnt);
    if (errors == 0 && u_dut.u_chk.fail_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- bench/cgra_init_checker.sv
`timescale 1ns/1ns

module cgra_init_checker import cgra_init_pkg::*; (
  input logic                  clk,
  input logic                  rst,
  input logic                  req_rd_data,
  input logic                  done,
  input logic                  rd_req,
  input logic                  rd_ack,
  input logic [INIT_BUS_W-1:0] rd_rec
);

  int fail_cnt = 0;

  // Memory requests are single-cycle pulses
  req_pulse_a: assert property (@(posedge clk) disable iff (rst)
    req_rd_data |=> !req_rd_data)
    else begin
      $error("req_rd_data stayed high for two cycles");
      fail_cnt++;
    end

  done_sticky_a: assert property (@(posedge clk) disable iff (rst) done |=> done)
    else begin
      $error("done fell outside reset");
      fail_cnt++;
    end

  ack_rise_a: assert property (@(posedge clk) disable iff (rst)
    $rose(rd_ack) |-> $past(rd_req))
    else begin
      $error("rd_ack rose without rd_req");
      fail_cnt++;
    end

  ack_fall_a: assert property (@(posedge clk) disable iff (rst)
    $fell(rd_ack) |-> !$past(rd_req))
    else begin
      $error("rd_ack fell while rd_req was still high");
      fail_cnt++;
    end

  // Reply held for the whole handshake
  rec_stable_a: assert property (@(posedge clk) disable iff (rst)
    (rd_ack && $past(rd_ack)) |-> $stable(rd_rec))
    else begin
      $error("rd_rec changed while rd_ack was high");
      fail_cnt++;
    end

endmodule

//--- hw/cgra_init_top.sv
`timescale 1ns/1ns

module cgra_init_top import cgra_init_pkg::*; #(
  parameter int NUM_PE = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  available_read,
  input  logic [LINE_W-1:0]     rd_data,
  input  logic                  rd_data_valid,
  input  logic                  rd_req,
  input  logic [PE_ID_W-1:0]    rd_sel,
  output logic                  req_rd_data,
  output logic [31:0]           qtd_conf,
  output logic [31:0]           qtd_net_conf,
  output logic [1:0]            read_fifo_mask,
  output logic [1:0]            write_fifo_mask,
  output logic                  done,
  output logic                  rd_ack,
  output logic [INIT_BUS_W-1:0] rd_rec,
  output logic                  rd_loaded
);

  logic                         conf_valid;
  logic [INIT_BUS_W-1:0]        conf_bus;
  logic [NUM_PE*INIT_BUS_W-1:0] slot_recs;
  logic [NUM_PE-1:0]            slot_loaded;

  cgra_initial_conf_control u_ctrl (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .available_read  (available_read),
    .rd_data         (rd_data),
    .rd_data_valid   (rd_data_valid),
    .req_rd_data     (req_rd_data),
    .conf_valid      (conf_valid),
    .conf_bus        (conf_bus),
    .qtd_conf        (qtd_conf),
    .qtd_net_conf    (qtd_net_conf),
    .read_fifo_mask  (read_fifo_mask),
    .write_fifo_mask (write_fifo_mask),
    .done            (done)
  );

  // One slot per PE, all listening on the same init bus
  for (genvar i = 0; i < NUM_PE; i++) begin : g_slot
    pe_init_slot #(
      .SLOT_ID (i)
    ) u_slot (
      .clk        (clk),
      .rst        (rst),
      .conf_valid (conf_valid),
      .conf_bus   (conf_bus),
      .rec        (slot_recs[i*INIT_BUS_W +: INIT_BUS_W]),
      .loaded     (slot_loaded[i])
    );
  end

  pe_conf_readout #(
    .NUM_PE (NUM_PE)
  ) u_readout (
    .clk         (clk),
    .rst         (rst),
    .slot_recs   (slot_recs),
    .slot_loaded (slot_loaded),
    .rd_req      (rd_req),
    .rd_sel      (rd_sel),
    .rd_ack      (rd_ack),
    .rd_rec      (rd_rec),
    .rd_loaded   (rd_loaded)
  );

endmodule

//--- hw/pe_conf_readout.sv
`timescale 1ns/1ns

module pe_conf_readout import cgra_init_pkg::*; #(
  parameter int NUM_PE = 8
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [NUM_PE*INIT_BUS_W-1:0] slot_recs,
  input  logic [NUM_PE-1:0]            slot_loaded,
  input  logic                         rd_req,
  input  logic [PE_ID_W-1:0]           rd_sel,
  output logic                         rd_ack,
  output logic [INIT_BUS_W-1:0]        rd_rec,
  output logic                         rd_loaded
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ACK,
    RD_RELEASE
  } rd_state_t;

  rd_state_t state;

  logic [INIT_BUS_W-1:0] sel_rec;
  logic                  sel_loaded;

  // Out of range selections answer with an empty record
  always_comb begin
    sel_rec    = '0;
    sel_loaded = 1'b0;
    for (int i = 0; i < NUM_PE; i++) begin
      if (int'(rd_sel) == i) begin
        sel_rec    = slot_recs[i*INIT_BUS_W +: INIT_BUS_W];
        sel_loaded = slot_loaded[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= RD_IDLE;
      rd_ack    <= 1'b0;
      rd_rec    <= '0;
      rd_loaded <= 1'b0;
    end else begin
      case (state)
        RD_IDLE: begin
          if (rd_req) begin
            rd_rec    <= sel_rec;
            rd_loaded <= sel_loaded;
            rd_ack    <= 1'b1;
            state     <= RD_ACK;
          end
        end
        RD_ACK: begin
          if (!rd_req) begin
            rd_ack <= 1'b0;
            state  <= RD_RELEASE;
          end
        end
        RD_RELEASE: begin
          // One idle cycle between transactions
          state <= RD_IDLE;
        end
        default: begin
          state <= RD_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/pe_init_slot.sv
`timescale 1ns/1ns

module pe_init_slot import cgra_init_pkg::*; #(
  parameter int SLOT_ID = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  conf_valid,
  input  logic [INIT_BUS_W-1:0] conf_bus,
  output logic [INIT_BUS_W-1:0] rec,
  output logic                  loaded
);

  logic hit;

  // Id sits in the low bits of the bus
  assign hit = conf_valid && (conf_bus[PE_ID_W-1:0] == PE_ID_W'(SLOT_ID));

  always_ff @(posedge clk) begin
    if (rst) begin
      rec    <= '0;
      loaded <= 1'b0;
    end else if (hit) begin
      // Last record for this id wins
      rec    <= conf_bus;
      loaded <= 1'b1;
    end
  end

endmodule

//--- hw/cgra_initial_conf_control.sv
`timescale 1ns/1ns

module cgra_initial_conf_control import cgra_init_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  logic                  available_read,
  input  logic [LINE_W-1:0]     rd_data,
  input  logic                  rd_data_valid,
  output logic                  req_rd_data,
  output logic                  conf_valid,
  output logic [INIT_BUS_W-1:0] conf_bus,
  output logic [31:0]           qtd_conf,
  output logic [31:0]           qtd_net_conf,
  output logic [1:0]            read_fifo_mask,
  output logic [1:0]            write_fifo_mask,
  output logic                  done
);

  localparam int LINE_CNT_W = $clog2(RECS_PER_LINE + 1);

  conf_state_t state;
  conf_state_t state_after_fetch;

  logic [LINE_W-1:0]     line_q;
  logic [31:0]           qtd_init_q;
  logic [31:0]           sent_cnt;
  logic [LINE_CNT_W-1:0] line_cnt;

  // First stage, one extracted record
  logic                send_q;
  logic [PE_ID_W-1:0]  id_q;
  logic [CONST_W-1:0]  const_q;
  logic [PC_MAX_W-1:0] pc_max_q;
  logic [LOOP_W-1:0]   loop_q;
  logic [IGNORE_W-1:0] ignore_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state             <= CONF_IDLE;
      state_after_fetch <= CONF_IDLE;
      req_rd_data       <= 1'b0;
      send_q            <= 1'b0;
      qtd_init_q        <= '0;
      sent_cnt          <= '0;
      // Starts full so the first send state fetches a line
      line_cnt          <= LINE_CNT_W'(RECS_PER_LINE);
      qtd_conf          <= '0;
      qtd_net_conf      <= '0;
      read_fifo_mask    <= '0;
      write_fifo_mask   <= '0;
      done              <= 1'b0;
    end else begin
      req_rd_data <= 1'b0;
      send_q      <= 1'b0;
      case (state)
        CONF_IDLE: begin
          if (start) begin
            state             <= CONF_REQ_DATA;
            state_after_fetch <= CONF_INIT;
          end
        end
        CONF_REQ_DATA: begin
          // Hold here while the memory is busy
          if (available_read) begin
            req_rd_data <= 1'b1;
            state       <= CONF_WAIT_DATA;
          end
        end
        CONF_WAIT_DATA: begin
          if (rd_data_valid) begin
            state <= state_after_fetch;
          end
        end
        CONF_INIT: begin
          qtd_init_q      <= line_q[HDR_COUNT_OFS +: 32];
          qtd_conf        <= line_q[HDR_CONF_OFS +: 32];
          qtd_net_conf    <= line_q[HDR_NET_OFS +: 32];
          read_fifo_mask  <= line_q[HDR_RMASK_OFS +: 2];
          write_fifo_mask <= line_q[HDR_WMASK_OFS +: 2];
          state           <= CONF_SEND;
        end
        CONF_SEND: begin
          if (sent_cnt >= qtd_init_q) begin
            state <= CONF_DONE;
          end else if (line_cnt < LINE_CNT_W'(RECS_PER_LINE)) begin
            send_q   <= 1'b1;
            sent_cnt <= sent_cnt + 32'd1;
            line_cnt <= line_cnt + 1'b1;
          end else begin
            line_cnt          <= '0;
            state             <= CONF_REQ_DATA;
            state_after_fetch <= CONF_SEND;
          end
        end
        CONF_DONE: begin
          done <= 1'b1;
        end
        default: begin
          state <= CONF_IDLE;
        end
      endcase
    end
  end

  // Line buffer and field extraction
  always_ff @(posedge clk) begin
    if (state == CONF_WAIT_DATA && rd_data_valid) begin
      line_q <= rd_data;
    end else if (state == CONF_SEND && sent_cnt < qtd_init_q &&
                 line_cnt < LINE_CNT_W'(RECS_PER_LINE)) begin
      id_q     <= line_q[REC_ID_OFS +: PE_ID_W];
      const_q  <= line_q[REC_CONST_OFS +: CONST_W];
      pc_max_q <= line_q[REC_PC_MAX_OFS +: PC_MAX_W];
      loop_q   <= line_q[REC_LOOP_OFS +: LOOP_W];
      ignore_q <= line_q[REC_IGNORE_OFS +: IGNORE_W];
      line_q   <= line_q >> REC_W;
    end
  end

  // Second stage drives the init bus
  always_ff @(posedge clk) begin
    if (rst) begin
      conf_valid <= 1'b0;
      conf_bus   <= '0;
    end else begin
      conf_valid <= send_q;
      if (send_q) begin
        conf_bus <= {ignore_q, loop_q, pc_max_q, const_q, id_q};
      end else begin
        conf_bus <= '0;
      end
    end
  end

endmodule

//--- hw/cgra_init_pkg.sv
package cgra_init_pkg;

  localparam int LINE_W        = 512;
  localparam int REC_W         = 128;
  localparam int RECS_PER_LINE = 4;
  localparam int INIT_BUS_W    = 45;
  localparam int PE_ID_W       = 5;
  localparam int MAX_PE        = 32;

  // Record field widths, packed from the low end of the init bus
  localparam int CONST_W  = 16;
  localparam int PC_MAX_W = 8;
  localparam int LOOP_W   = 8;
  localparam int IGNORE_W = 8;

  // Field positions inside one record slice
  localparam int REC_ID_OFS     = 0;
  localparam int REC_CONST_OFS  = 16;
  localparam int REC_PC_MAX_OFS = 32;
  localparam int REC_LOOP_OFS   = 64;
  localparam int REC_IGNORE_OFS = 96;

  // Header line layout
  localparam int HDR_COUNT_OFS = 0;
  localparam int HDR_CONF_OFS  = 32;
  localparam int HDR_NET_OFS   = 64;
  localparam int HDR_RMASK_OFS = 96;
  localparam int HDR_WMASK_OFS = 128;

  typedef enum logic [2:0] {
    CONF_IDLE,
    CONF_REQ_DATA,
    CONF_WAIT_DATA,
    CONF_INIT,
    CONF_SEND,
    CONF_DONE
  } conf_state_t;

endpackage
